// File: pcie_app_pkg.sv
// PCIe application shared definitions

package pcie_app_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int DATA_W      = 64;
  localparam int KEEP_W      = DATA_W / 8;
  localparam int REG_ADDR_W  = 10;
  localparam int USER_ADDR_W = 9;

  // Read-only ID at register address 0
  localparam logic [31:0] DESIGN_ID = 32'hA5E0_0101;

  // ------------------------------
  // TLP fmt/type codes
  // ------------------------------
  localparam logic [7:0] FMT_TYPE_MRD32 = 8'h00;
  localparam logic [7:0] FMT_TYPE_MWR32 = 8'h40;
  localparam logic [7:0] FMT_TYPE_CPLD  = 8'h4A;

  // One rx beat, seen either as the request header or as address plus data
  typedef union packed {
    struct packed {
      logic [15:0] rid;
      logic [7:0]  tag;
      logic [3:0]  last_be;
      logic [3:0]  first_be;
      logic [7:0]  fmt_type;
      logic        rsvd0;
      logic [2:0]  tc;
      logic [3:0]  rsvd1;
      logic        td;
      logic        ep;
      logic [1:0]  attr;
      logic [1:0]  rsvd2;
      logic [9:0]  length;
    } hdr;
    struct packed {
      logic [31:0] data;
      logic [29:0] addr;
      logic [1:0]  addr_rsvd;
    } ad;
  } tlp_beat_u;

  // TLP payload is big-endian per dword
  function automatic logic [31:0] dw_swap(input logic [31:0] dw);
    return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
  endfunction

endpackage

// File: pcie_rx_engine.sv
// PCIe request receive engine

`timescale 1ns/100ps

module pcie_rx_engine
  import pcie_app_pkg::*;
(
  input  logic                  pcie_core_clk_i,
  input  logic                  rst_n_i,
  // AXI-Stream rx from the core
  input  logic [DATA_W-1:0]     m_axis_rx_tdata_i,
  input  logic                  m_axis_rx_tlast_i,
  input  logic                  m_axis_rx_tvalid_i,
  output logic                  m_axis_rx_tready_o,
  // Register file
  output logic [REG_ADDR_W-1:0] reg_addr_o,
  output logic [31:0]           reg_wdata_o,
  output logic                  reg_wr_o,
  input  logic                  reg_wr_ack_i,
  output logic                  reg_rd_o,
  input  logic                  reg_rd_ack_i,
  input  logic [31:0]           reg_rdata_i,
  // Completion request to tx
  output logic                  req_compl_o,
  input  logic                  compl_done_i,
  output logic [2:0]            req_tc_o,
  output logic [1:0]            req_attr_o,
  output logic [15:0]           req_rid_o,
  output logic [7:0]            req_tag_o,
  output logic [6:0]            req_addr_o,
  output logic [31:0]           cpl_data_o
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_HDR      = 3'd1;
  localparam logic [2:0] ST_DISCARD  = 3'd2;
  localparam logic [2:0] ST_WRITE    = 3'd3;
  localparam logic [2:0] ST_READ     = 3'd4;
  localparam logic [2:0] ST_CPL_WAIT = 3'd5;

  logic [2:0] state_q;
  tlp_beat_u  beat;
  logic       beat_ok;
  logic       hdr_supported;
  logic       is_wr_q;

  assign beat    = m_axis_rx_tdata_i;
  assign beat_ok = m_axis_rx_tvalid_i && m_axis_rx_tready_o;

  // Only 3-DW single-dword memory requests
  assign hdr_supported = ((beat.hdr.fmt_type == FMT_TYPE_MRD32) ||
                          (beat.hdr.fmt_type == FMT_TYPE_MWR32)) &&
                         (beat.hdr.length == 10'd1);

  // Accept beats until the access is handed off
  assign m_axis_rx_tready_o = (state_q == ST_IDLE) || (state_q == ST_HDR) ||
                              (state_q == ST_DISCARD);

  // ------------------------------
  // Request FSM
  // ------------------------------
  always_ff @(posedge pcie_core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= ST_IDLE;
      is_wr_q     <= 1'b0;
      reg_wr_o    <= 1'b0;
      reg_rd_o    <= 1'b0;
      req_compl_o <= 1'b0;
    end
    else
    begin
      reg_wr_o <= 1'b0;
      case (state_q)
        ST_IDLE:
          if (beat_ok && !m_axis_rx_tlast_i)
          begin
            if (hdr_supported)
            begin
              state_q <= ST_HDR;
              is_wr_q <= (beat.hdr.fmt_type == FMT_TYPE_MWR32);
            end
            else
              state_q <= ST_DISCARD;
          end
        ST_HDR:
          if (beat_ok)
          begin
            if (is_wr_q)
            begin
              reg_wr_o <= 1'b1;
              state_q  <= ST_WRITE;
            end
            else
            begin
              reg_rd_o <= 1'b1;
              state_q  <= ST_READ;
            end
          end
        ST_DISCARD:
          if (beat_ok && m_axis_rx_tlast_i)
            state_q <= ST_IDLE;
        ST_WRITE:
          if (reg_wr_ack_i)
            state_q <= ST_IDLE;
        ST_READ:
          if (reg_rd_ack_i)
          begin
            reg_rd_o    <= 1'b0;
            req_compl_o <= 1'b1;
            state_q     <= ST_CPL_WAIT;
          end
        ST_CPL_WAIT:
          if (compl_done_i)
          begin
            req_compl_o <= 1'b0;
            state_q     <= ST_IDLE;
          end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // Header fields, address and data
  always_ff @(posedge pcie_core_clk_i)
  begin
    if (beat_ok && (state_q == ST_IDLE))
    begin
      req_tc_o   <= beat.hdr.tc;
      req_attr_o <= beat.hdr.attr;
      req_rid_o  <= beat.hdr.rid;
      req_tag_o  <= beat.hdr.tag;
    end
    if (beat_ok && (state_q == ST_HDR))
    begin
      reg_addr_o  <= beat.ad.addr[REG_ADDR_W-1:0];
      reg_wdata_o <= dw_swap(beat.ad.data);
      req_addr_o  <= {beat.ad.addr[4:0], 2'b00};
    end
    if ((state_q == ST_READ) && reg_rd_ack_i)
      cpl_data_o <= reg_rdata_i;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_no_wr_rd: assert property (@(posedge pcie_core_clk_i) disable iff (!rst_n_i)
    !(reg_wr_o && reg_rd_o));

  // Completion request held until tx reports the last beat
  a_compl_held: assert property (@(posedge pcie_core_clk_i) disable iff (!rst_n_i)
    req_compl_o && !compl_done_i |=> req_compl_o);

endmodule

// File: pcie_reg_file.sv
// PCIe register file and user window

`timescale 1ns/100ps

module pcie_reg_file
  import pcie_app_pkg::*;
#(
  parameter int NUM_REGS = 16
)
(
  input  logic                   pcie_core_clk_i,
  input  logic                   rst_n_i,
  // Rx engine
  input  logic [REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [31:0]            reg_wdata_i,
  input  logic                   reg_wr_i,
  output logic                   reg_wr_ack_o,
  input  logic                   reg_rd_i,
  output logic                   reg_rd_ack_o,
  output logic [31:0]            reg_rdata_o,
  // User bus
  output logic [USER_ADDR_W-1:0] user_addr_o,
  output logic [31:0]            user_data_o,
  output logic                   user_wr_req_o,
  input  logic [31:0]            user_data_i,
  input  logic                   user_rd_ack_i,
  output logic                   user_rd_req_o
);

  logic [31:0] regs_q [1:NUM_REGS-1];
  logic        sel_id;
  logic        sel_scratch;
  logic        sel_user;
  logic        rd_start;
  logic [31:0] local_rdata;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign sel_user    = reg_addr_i[REG_ADDR_W-1];
  assign sel_id      = (reg_addr_i == '0);
  assign sel_scratch = !sel_user && !sel_id && (reg_addr_i < REG_ADDR_W'(NUM_REGS));

  // reg_rd is a level, so start only once per request
  assign rd_start = reg_rd_i && !reg_rd_ack_o && !user_rd_req_o;

  always_comb
  begin
    if (sel_id)
      local_rdata = DESIGN_ID;
    else if (sel_scratch)
      local_rdata = regs_q[reg_addr_i];
    else
      local_rdata = '0;
  end

  // Scratch registers
  always_ff @(posedge pcie_core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (reg_wr_i && sel_scratch)
      regs_q[reg_addr_i] <= reg_wdata_i;
  end

  // ------------------------------
  // Acks and user requests
  // ------------------------------
  always_ff @(posedge pcie_core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reg_wr_ack_o  <= 1'b0;
      reg_rd_ack_o  <= 1'b0;
      user_wr_req_o <= 1'b0;
      user_rd_req_o <= 1'b0;
    end
    else
    begin
      reg_wr_ack_o  <= reg_wr_i;
      user_wr_req_o <= reg_wr_i && sel_user;
      reg_rd_ack_o  <= (rd_start && !sel_user) || (user_rd_req_o && user_rd_ack_i);
      if (rd_start && sel_user)
        user_rd_req_o <= 1'b1;
      else if (user_rd_ack_i)
        user_rd_req_o <= 1'b0;
    end
  end

  // Read data and user bus payload
  always_ff @(posedge pcie_core_clk_i)
  begin
    if (rd_start && !sel_user)
      reg_rdata_o <= local_rdata;
    else if (user_rd_req_o && user_rd_ack_i)
      reg_rdata_o <= user_data_i;
    if ((reg_wr_i || rd_start) && sel_user)
      user_addr_o <= reg_addr_i[USER_ADDR_W-1:0];
    if (reg_wr_i && sel_user)
      user_data_o <= reg_wdata_i;
  end

  a_user_excl: assert property (@(posedge pcie_core_clk_i) disable iff (!rst_n_i)
    !(user_wr_req_o && user_rd_req_o));

endmodule

// File: pcie_tx_engine.sv
// PCIe completion transmit engine

`timescale 1ns/100ps

module pcie_tx_engine
  import pcie_app_pkg::*;
(
  input  logic              pcie_core_clk_i,
  input  logic              rst_n_i,
  // AXI-Stream tx to the core
  input  logic              s_axis_tx_tready_i,
  output logic [DATA_W-1:0] s_axis_tx_tdata_o,
  output logic [KEEP_W-1:0] s_axis_tx_tkeep_o,
  output logic              s_axis_tx_tlast_o,
  output logic              s_axis_tx_tvalid_o,
  // Completion request from rx
  input  logic              req_compl_i,
  output logic              compl_done_o,
  input  logic [2:0]        req_tc_i,
  input  logic [1:0]        req_attr_i,
  input  logic [15:0]       req_rid_i,
  input  logic [7:0]        req_tag_i,
  input  logic [6:0]        req_addr_i,
  input  logic [31:0]       cpl_data_i,
  input  logic [15:0]       completer_id_i
);

  localparam logic [1:0] TX_IDLE  = 2'd0;
  localparam logic [1:0] TX_BEAT0 = 2'd1;
  localparam logic [1:0] TX_BEAT1 = 2'd2;

  logic [1:0]  state_q;
  logic [31:0] cpl_dw0;
  logic [31:0] cpl_dw1;
  logic [31:0] cpl_dw2;
  logic        beat_acc;

  // ------------------------------
  // CplD header dwords
  // ------------------------------
  // fmt/type, TC, TD/EP clear, attributes, length 1
  assign cpl_dw0 = {FMT_TYPE_CPLD, 1'b0, req_tc_i, 4'b0000, 2'b00, req_attr_i, 2'b00, 10'd1};
  // Completer ID, successful status, BCM clear, byte count 4
  assign cpl_dw1 = {completer_id_i, 3'b000, 1'b0, 12'd4};
  assign cpl_dw2 = {req_rid_i, req_tag_i, 1'b0, req_addr_i};

  assign s_axis_tx_tvalid_o = (state_q != TX_IDLE);
  assign s_axis_tx_tlast_o  = (state_q == TX_BEAT1);
  assign s_axis_tx_tkeep_o  = '1;

  assign beat_acc     = s_axis_tx_tvalid_o && s_axis_tx_tready_i;
  assign compl_done_o = beat_acc && s_axis_tx_tlast_o;

  // ------------------------------
  // Sender FSM
  // ------------------------------
  always_ff @(posedge pcie_core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= TX_IDLE;
    else
    begin
      case (state_q)
        TX_IDLE:
          if (req_compl_i)
            state_q <= TX_BEAT0;
        TX_BEAT0:
          if (s_axis_tx_tready_i)
            state_q <= TX_BEAT1;
        TX_BEAT1:
          if (s_axis_tx_tready_i)
            state_q <= TX_IDLE;
        default:
          state_q <= TX_IDLE;
      endcase
    end
  end

  // Beat contents, held while tready is low
  always_ff @(posedge pcie_core_clk_i)
  begin
    if ((state_q == TX_IDLE) && req_compl_i)
      s_axis_tx_tdata_o <= {cpl_dw1, cpl_dw0};
    else if ((state_q == TX_BEAT0) && s_axis_tx_tready_i)
      s_axis_tx_tdata_o <= {dw_swap(cpl_data_i), cpl_dw2};
  end

  a_beat_hold: assert property (@(posedge pcie_core_clk_i) disable iff (!rst_n_i)
    s_axis_tx_tvalid_o && !s_axis_tx_tready_i |=>
      $stable(s_axis_tx_tdata_o) && $stable(s_axis_tx_tlast_o));

endmodule

// File: pcie_app.sv
// PCIe application top

`timescale 1ns/100ps

module pcie_app
  import pcie_app_pkg::*;
#(
  parameter int NUM_REGS = 16
)
(
  input  logic                   pcie_core_clk_i,
  input  logic                   rst_n_i,
  // Tx stream
  input  logic                   s_axis_tx_tready_i,
  output logic [DATA_W-1:0]      s_axis_tx_tdata_o,
  output logic [KEEP_W-1:0]      s_axis_tx_tkeep_o,
  output logic                   s_axis_tx_tlast_o,
  output logic                   s_axis_tx_tvalid_o,
  // Rx stream
  input  logic [DATA_W-1:0]      m_axis_rx_tdata_i,
  input  logic                   m_axis_rx_tlast_i,
  input  logic                   m_axis_rx_tvalid_i,
  output logic                   m_axis_rx_tready_o,
  // Config space
  input  logic [7:0]             cfg_bus_number_i,
  input  logic [4:0]             cfg_device_number_i,
  input  logic [2:0]             cfg_function_number_i,
  // User bus
  output logic [31:0]            user_data_o,
  output logic [USER_ADDR_W-1:0] user_addr_o,
  output logic                   user_wr_req_o,
  input  logic [31:0]            user_data_i,
  input  logic                   user_rd_ack_i,
  output logic                   user_rd_req_o
);

  logic [15:0]           completer_id;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [31:0]           reg_wdata;
  logic                  reg_wr;
  logic                  reg_wr_ack;
  logic                  reg_rd;
  logic                  reg_rd_ack;
  logic [31:0]           reg_rdata;
  logic                  req_compl;
  logic                  compl_done;
  logic [2:0]            req_tc;
  logic [1:0]            req_attr;
  logic [15:0]           req_rid;
  logic [7:0]            req_tag;
  logic [6:0]            req_addr;
  logic [31:0]           cpl_data;

  // Bus, device, function
  assign completer_id = {cfg_bus_number_i, cfg_device_number_i, cfg_function_number_i};

  // ------------------------------
  // Receive
  // ------------------------------
  pcie_rx_engine rx_engine0 (
    .pcie_core_clk_i    (pcie_core_clk_i),
    .rst_n_i            (rst_n_i),
    .m_axis_rx_tdata_i  (m_axis_rx_tdata_i),
    .m_axis_rx_tlast_i  (m_axis_rx_tlast_i),
    .m_axis_rx_tvalid_i (m_axis_rx_tvalid_i),
    .m_axis_rx_tready_o (m_axis_rx_tready_o),
    .reg_addr_o         (reg_addr),
    .reg_wdata_o        (reg_wdata),
    .reg_wr_o           (reg_wr),
    .reg_wr_ack_i       (reg_wr_ack),
    .reg_rd_o           (reg_rd),
    .reg_rd_ack_i       (reg_rd_ack),
    .reg_rdata_i        (reg_rdata),
    .req_compl_o        (req_compl),
    .compl_done_i       (compl_done),
    .req_tc_o           (req_tc),
    .req_attr_o         (req_attr),
    .req_rid_o          (req_rid),
    .req_tag_o          (req_tag),
    .req_addr_o         (req_addr),
    .cpl_data_o         (cpl_data)
  );

  // Registers and user window
  pcie_reg_file #(
    .NUM_REGS (NUM_REGS)
  ) reg_file0 (
    .pcie_core_clk_i (pcie_core_clk_i),
    .rst_n_i         (rst_n_i),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_wr_i        (reg_wr),
    .reg_wr_ack_o    (reg_wr_ack),
    .reg_rd_i        (reg_rd),
    .reg_rd_ack_o    (reg_rd_ack),
    .reg_rdata_o     (reg_rdata),
    .user_addr_o     (user_addr_o),
    .user_data_o     (user_data_o),
    .user_wr_req_o   (user_wr_req_o),
    .user_data_i     (user_data_i),
    .user_rd_ack_i   (user_rd_ack_i),
    .user_rd_req_o   (user_rd_req_o)
  );

  // ------------------------------
  // Transmit
  // ------------------------------
  pcie_tx_engine tx_engine0 (
    .pcie_core_clk_i    (pcie_core_clk_i),
    .rst_n_i            (rst_n_i),
    .s_axis_tx_tready_i (s_axis_tx_tready_i),
    .s_axis_tx_tdata_o  (s_axis_tx_tdata_o),
    .s_axis_tx_tkeep_o  (s_axis_tx_tkeep_o),
    .s_axis_tx_tlast_o  (s_axis_tx_tlast_o),
    .s_axis_tx_tvalid_o (s_axis_tx_tvalid_o),
    .req_compl_i        (req_compl),
    .compl_done_o       (compl_done),
    .req_tc_i           (req_tc),
    .req_attr_i         (req_attr),
    .req_rid_i          (req_rid),
    .req_tag_i          (req_tag),
    .req_addr_i         (req_addr),
    .cpl_data_i         (cpl_data),
    .completer_id_i     (completer_id)
  );

endmodule

// File: tb_pcie_app.sv
// PCIe application testbench

`timescale 1ns/100ps

module tb_pcie_app
  import pcie_app_pkg::*;
();

  localparam int NUM_REGS = 16;
  localparam int TIMEOUT  = 200;

  // One outstanding read as seen by the model
  typedef struct packed {
    logic        from_user;
    logic [2:0]  tc;
    logic [1:0]  attr;
    logic [15:0] rid;
    logic [7:0]  tag;
    logic [6:0]  laddr;
    logic [31:0] value;
  } cpl_exp_t;

  logic                   clk;
  logic                   rst_n;
  logic                   tx_tready;
  logic [DATA_W-1:0]      tx_tdata;
  logic [KEEP_W-1:0]      tx_tkeep;
  logic                   tx_tlast;
  logic                   tx_tvalid;
  logic [DATA_W-1:0]      rx_tdata;
  logic                   rx_tlast;
  logic                   rx_tvalid;
  logic                   rx_tready;
  logic [7:0]             cfg_bus;
  logic [4:0]             cfg_dev;
  logic [2:0]             cfg_func;
  logic [15:0]            completer_id;
  logic [31:0]            user_wdata;
  logic [USER_ADDR_W-1:0] user_addr;
  logic                   user_wr_req;
  logic [31:0]            user_rdata;
  logic                   user_rd_ack;
  logic                   user_rd_req;

  logic [31:0] model_regs [0:1023];
  cpl_exp_t    exp_mem [0:255];
  int          exp_wr_idx = 0;
  int          exp_rd_idx = 0;
  int          cpl_count = 0;
  int          mon_errs = 0;
  int          beat_idx = 0;
  logic [63:0] beat0;
  logic        hold_valid = 1'b0;
  logic [63:0] hold_data;
  logic        hold_last;
  logic [8:0]  user_wr_log_addr [0:63];
  logic [31:0] user_wr_log_data [0:63];
  int          user_wr_count = 0;
  logic [31:0] user_rd_data [0:63];
  logic [8:0]  user_rd_log_addr [0:63];
  int          user_rd_idx = 0;
  int          user_ack_count = 0;
  int          err_count = 0;
  int          test_err_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic        bp_en;
  logic [9:0]  addr_list [0:7];

  assign completer_id = {cfg_bus, cfg_dev, cfg_func};

  pcie_app #(
    .NUM_REGS (NUM_REGS)
  ) dut0 (
    .pcie_core_clk_i       (clk),
    .rst_n_i               (rst_n),
    .s_axis_tx_tready_i    (tx_tready),
    .s_axis_tx_tdata_o     (tx_tdata),
    .s_axis_tx_tkeep_o     (tx_tkeep),
    .s_axis_tx_tlast_o     (tx_tlast),
    .s_axis_tx_tvalid_o    (tx_tvalid),
    .m_axis_rx_tdata_i     (rx_tdata),
    .m_axis_rx_tlast_i     (rx_tlast),
    .m_axis_rx_tvalid_i    (rx_tvalid),
    .m_axis_rx_tready_o    (rx_tready),
    .cfg_bus_number_i      (cfg_bus),
    .cfg_device_number_i   (cfg_dev),
    .cfg_function_number_i (cfg_func),
    .user_data_o           (user_wdata),
    .user_addr_o           (user_addr),
    .user_wr_req_o         (user_wr_req),
    .user_data_i           (user_rdata),
    .user_rd_ack_i         (user_rd_ack),
    .user_rd_req_o         (user_rd_req)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] byte_reverse(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] model_read(input logic [9:0] addr);
    if (addr == 10'd0)
      return DESIGN_ID;
    else if (!addr[9] && (addr < NUM_REGS))
      return model_regs[addr];
    return 32'h0;
  endfunction

  // Completion beats {beat1, beat0} for a read that returned value
  function automatic logic [127:0] expected_cpl(input cpl_exp_t e, input logic [31:0] value);
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;
    dw0 = {FMT_TYPE_CPLD, 1'b0, e.tc, 4'h0, 1'b0, 1'b0, e.attr, 2'b00, 10'd1};
    dw1 = {completer_id, 3'b000, 1'b0, 12'd4};
    dw2 = {e.rid, e.tag, 1'b0, e.laddr};
    return {byte_reverse(value), dw2, dw1, dw0};
  endfunction

  function automatic cpl_exp_t new_fields(input logic [9:0] addr);
    cpl_exp_t e;
    e.from_user = addr[9];
    e.tc        = 3'($urandom);
    e.attr      = 2'($urandom);
    e.rid       = 16'($urandom);
    e.tag       = 8'($urandom);
    e.laddr     = {addr[4:0], 2'b00};
    e.value     = 32'h0;
    return e;
  endfunction

  function automatic logic [63:0] make_hdr(input logic [7:0] fmt, input logic [9:0] len,
                                           input cpl_exp_t e);
    return {e.rid, e.tag, 4'h0, 4'hF, fmt, 1'b0, e.tc, 4'h0, 1'b0, 1'b0, e.attr, 2'b00, len};
  endfunction

  // Upper address bits are outside the register decode
  function automatic logic [31:0] addr_dword(input logic [9:0] addr);
    return {20'($urandom), addr, 2'b00};
  endfunction

  // ------------------------------
  // Completion and user-bus monitor
  // ------------------------------
  always @(posedge clk)
  begin : tx_monitor
    cpl_exp_t     e;
    logic [31:0]  value;
    logic [127:0] exp_beats;
    if (rst_n)
    begin
      if (hold_valid && (tx_tdata !== hold_data))
      begin
        $display("mismatch s_axis_tx_tdata_o held: got %h expected %h", tx_tdata, hold_data);
        mon_errs++;
      end
      if (hold_valid && (tx_tlast !== hold_last))
      begin
        $display("mismatch s_axis_tx_tlast_o held: got %h expected %h", tx_tlast, hold_last);
        mon_errs++;
      end
      hold_valid = tx_tvalid && !tx_tready;
      hold_data  = tx_tdata;
      hold_last  = tx_tlast;
      if (user_wr_req)
      begin
        user_wr_log_addr[user_wr_count] = user_addr;
        user_wr_log_data[user_wr_count] = user_wdata;
        user_wr_count++;
      end
      if (tx_tvalid && tx_tready)
      begin
        if (tx_tkeep !== '1)
        begin
          $display("mismatch s_axis_tx_tkeep_o: got %h expected %h", tx_tkeep, 8'hFF);
          mon_errs++;
        end
        if (beat_idx == 0)
        begin
          if (tx_tlast)
          begin
            $display("completion ended after a single beat");
            mon_errs++;
          end
          else
          begin
            beat0    = tx_tdata;
            beat_idx = 1;
          end
        end
        else
        begin
          beat_idx = 0;
          if (!tx_tlast)
          begin
            $display("completion second beat came without tlast");
            mon_errs++;
          end
          else if (exp_rd_idx == exp_wr_idx)
          begin
            $display("completion sent with no read outstanding");
            mon_errs++;
          end
          else
          begin
            e = exp_mem[exp_rd_idx];
            exp_rd_idx++;
            value = e.value;
            if (e.from_user)
            begin
              value = user_rd_data[user_rd_idx];
              user_rd_idx++;
            end
            exp_beats = expected_cpl(e, value);
            if (beat0 !== exp_beats[63:0])
            begin
              $display("mismatch s_axis_tx_tdata_o beat 0: got %h expected %h",
                       beat0, exp_beats[63:0]);
              mon_errs++;
            end
            if (tx_tdata !== exp_beats[127:64])
            begin
              $display("mismatch s_axis_tx_tdata_o beat 1: got %h expected %h",
                       tx_tdata, exp_beats[127:64]);
              mon_errs++;
            end
            cpl_count++;
          end
        end
      end
    end
  end

  // User read responder, random delay and data
  initial
  begin
    user_rd_ack = 1'b0;
    user_rdata  = 32'h0;
    forever
    begin
      @(negedge clk);
      if (user_rd_req && rst_n)
      begin
        repeat ($urandom_range(0, 5)) @(negedge clk);
        user_rdata  = $urandom;
        user_rd_ack = 1'b1;
        user_rd_data[user_ack_count]     = user_rdata;
        user_rd_log_addr[user_ack_count] = user_addr;
        user_ack_count++;
        @(negedge clk);
        user_rd_ack = 1'b0;
      end
    end
  end

  // Tx back-pressure
  initial
  begin
    tx_tready = 1'b1;
    forever
    begin
      @(negedge clk);
      if (bp_en)
        tx_tready = ($urandom_range(0, 2) != 0);
      else
        tx_tready = 1'b1;
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  // Compare a single-bit DUT output
  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic send_beat(input logic [63:0] data, input logic last);
    int n;
    n = 0;
    @(negedge clk);
    rx_tdata  = data;
    rx_tvalid = 1'b1;
    rx_tlast  = last;
    @(posedge clk);
    while (!rx_tready)
    begin
      n++;
      if (n > TIMEOUT)
        abort_run("rx stream never accepted a beat");
      @(posedge clk);
    end
  endtask

  task automatic end_packet();
    @(negedge clk);
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    rx_tdata  = '0;
  endtask

  task automatic wait_rx_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (!rx_tready)
    begin
      n++;
      if (n > TIMEOUT)
        abort_run("rx engine stayed busy after a request");
      @(negedge clk);
    end
  endtask

  task automatic do_write(input logic [9:0] addr, input logic [31:0] payload);
    cpl_exp_t e;
    int       wr_start;
    e        = new_fields(addr);
    wr_start = user_wr_count;
    send_beat(make_hdr(FMT_TYPE_MWR32, 10'd1, e), 1'b0);
    send_beat({payload, addr_dword(addr)}, 1'b1);
    end_packet();
    wait_rx_idle();
    if (addr[9])
    begin
      if (user_wr_count != wr_start + 1)
      begin
        $display("user write gave %0d pulses instead of one", user_wr_count - wr_start);
        err_count++;
      end
      else
      begin
        if (user_wr_log_addr[wr_start] !== addr[8:0])
        begin
          $display("mismatch user_addr_o: got %h expected %h",
                   user_wr_log_addr[wr_start], addr[8:0]);
          err_count++;
        end
        if (user_wr_log_data[wr_start] !== byte_reverse(payload))
        begin
          $display("mismatch user_data_o: got %h expected %h",
                   user_wr_log_data[wr_start], byte_reverse(payload));
          err_count++;
        end
      end
    end
    else
    begin
      if (user_wr_count != wr_start)
      begin
        $display("local write reached the user bus");
        err_count++;
      end
      if ((addr != 10'd0) && (addr < NUM_REGS))
        model_regs[addr] = byte_reverse(payload);
    end
  endtask

  task automatic do_read(input logic [9:0] addr);
    cpl_exp_t e;
    int       cpl_start;
    int       ack_start;
    int       n;
    e       = new_fields(addr);
    e.value = model_read(addr);
    exp_mem[exp_wr_idx] = e;
    exp_wr_idx++;
    cpl_start = cpl_count;
    ack_start = user_ack_count;
    n = 0;
    send_beat(make_hdr(FMT_TYPE_MRD32, 10'd1, e), 1'b0);
    send_beat({32'h0, addr_dword(addr)}, 1'b1);
    end_packet();
    while (cpl_count == cpl_start)
    begin
      n++;
      if (n > TIMEOUT)
        abort_run("no completion came for a memory read");
      @(negedge clk);
    end
    if (addr[9])
    begin
      if (user_ack_count != ack_start + 1)
      begin
        $display("user read request was not raised exactly once");
        err_count++;
      end
      else if (user_rd_log_addr[ack_start] !== addr[8:0])
      begin
        $display("mismatch user_addr_o: got %h expected %h",
                 user_rd_log_addr[ack_start], addr[8:0]);
        err_count++;
      end
    end
    else if (user_ack_count != ack_start)
    begin
      $display("local read reached the user bus");
      err_count++;
    end
  endtask

  // Header, one address beat, then extra data beats
  task automatic send_unsupported(input logic [7:0] fmt, input logic [9:0] len,
                                  input logic [9:0] addr, input int extra);
    cpl_exp_t e;
    int       wr_start;
    int       ack_start;
    e         = new_fields(addr);
    wr_start  = user_wr_count;
    ack_start = user_ack_count;
    send_beat(make_hdr(fmt, len, e), 1'b0);
    send_beat({32'($urandom), addr_dword(addr)}, extra == 0);
    for (int i = 0; i < extra; i++)
      send_beat({32'($urandom), 32'($urandom)}, i == extra - 1);
    end_packet();
    wait_rx_idle();
    repeat (16) @(negedge clk);
    if ((user_wr_count != wr_start) || (user_ack_count != ack_start))
    begin
      $display("discarded request reached the user bus");
      err_count++;
    end
  endtask

  task automatic begin_test();
    test_err_start = err_count + mon_errs;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    if (err_count + mon_errs == test_err_start)
    begin
      $display("test %s: pass", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s: fail", name);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    void'($urandom(11359));
    rst_n     = 1'b0;
    rx_tdata  = '0;
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    cfg_bus   = 8'h3C;
    cfg_dev   = 5'h11;
    cfg_func  = 3'h5;
    bp_en     = 1'b0;
    for (int i = 0; i < 1024; i++)
      model_regs[i] = 32'h0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test();
    check_level("m_axis_rx_tready_o", rx_tready, 1'b1);
    check_level("s_axis_tx_tvalid_o", tx_tvalid, 1'b0);
    check_level("user_wr_req_o", user_wr_req, 1'b0);
    check_level("user_rd_req_o", user_rd_req, 1'b0);
    finish_test("reset values");

    begin_test();
    for (int i = 0; i < 6; i++)
    begin
      addr_list[i] = 10'($urandom_range(1, NUM_REGS - 1));
      do_write(addr_list[i], $urandom);
    end
    for (int i = 0; i < 6; i++)
      do_read(addr_list[i]);
    finish_test("local write and read back");

    begin_test();
    do_read(10'd0);
    do_write(10'd0, $urandom);
    do_read(10'd0);
    do_read(10'd100);
    do_write(10'd200, $urandom);
    do_read(10'd200);
    do_read(10'd511);
    finish_test("ID register and unmapped addresses");

    begin_test();
    for (int i = 0; i < 3; i++)
      do_write({1'b1, 9'($urandom)}, $urandom);
    finish_test("user window write");

    begin_test();
    for (int i = 0; i < 3; i++)
      do_read({1'b1, 9'($urandom)});
    finish_test("user window read");

    begin_test();
    @(posedge clk);
    bp_en = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      addr_list[i] = 10'($urandom_range(1, NUM_REGS - 1));
      do_write(addr_list[i], $urandom);
    end
    for (int i = 0; i < 8; i++)
    begin
      if (i % 3 == 2)
        do_read({1'b1, 9'($urandom)});
      else
        do_read(addr_list[i]);
    end
    @(posedge clk);
    bp_en = 1'b0;
    finish_test("back-pressure");

    begin_test();
    do_write(10'd5, $urandom);
    // 4-DW read and write, then length 2
    send_unsupported(8'h20, 10'd1, 10'd5, 0);
    send_unsupported(8'h60, 10'd1, 10'd5, 1);
    send_unsupported(FMT_TYPE_MWR32, 10'd2, 10'd5, 1);
    send_unsupported(FMT_TYPE_MRD32, 10'd2, 10'd5, 0);
    send_unsupported(FMT_TYPE_MWR32, 10'd2, 10'h210, 1);
    send_unsupported(FMT_TYPE_MRD32, 10'd2, 10'h210, 0);
    do_read(10'd5);
    do_read(10'h210);
    finish_test("unsupported packets");

    $display("tests passed %0d failed %0d, errors %0d",
             tests_passed, tests_failed, err_count + mon_errs);
    if ((tests_failed == 0) && (err_count + mon_errs == 0))
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: pcie_app.f
pcie_app_pkg.sv
pcie_rx_engine.sv
pcie_reg_file.sv
pcie_tx_engine.sv
pcie_app.sv
tb_pcie_app.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_pcie_app
FILELIST  = pcie_app.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
